// ==== rtl/soc_pkg.sv ====
// ----------------------------------------------------------------------
// Shared types and constants for the bus fabric slice
// Holds the Wishbone and CSR bus structs, the address map, the
// system controller register layout and the LED timing constant
// Modules import it inside their body and use scoped names in ports
// ----------------------------------------------------------------------
package soc_pkg;

	// ------------------------------------------------------------------
	// Bus structs
	// ------------------------------------------------------------------
	// Master request, 71 bits
	typedef struct packed {
		logic [31:0] adr;
		logic [31:0] dat;
		logic [3:0]  sel;
		logic        we;
		logic        cyc;
		logic        stb;
	} wb_req_t;

	// Target response, read data valid with ack
	typedef struct packed {
		logic [31:0] dat;
		logic        ack;
	} wb_rsp_t;

	// One CSR access, write strobe lasts a single cycle
	typedef struct packed {
		logic [13:0] adr;
		logic        we;
		logic [31:0] dat;
	} csr_req_t;

	// Interrupt pulses
	typedef struct packed {
		logic gpio;
		logic timer;
	} irq_t;

	// ------------------------------------------------------------------
	// Address map
	// ------------------------------------------------------------------
	// Compared against adr[31:29]
	localparam logic [2:0] REGION_BRAM = 3'b000;
	localparam logic [2:0] REGION_CSR  = 3'b100;
	// Word address width, 4 KB of RAM
	localparam int BRAM_ADDR_W = 10;

	// ------------------------------------------------------------------
	// CSR layout
	// ------------------------------------------------------------------
	// Bank compared with csr adr[13:10]
	localparam logic [3:0] SYSCTL_BANK = 4'h1;
	// Word offsets within the bank
	localparam logic [9:0] CSR_GPIO_IN       = 10'd0;
	localparam logic [9:0] CSR_GPIO_OUT      = 10'd1;
	localparam logic [9:0] CSR_TIMER_CTRL    = 10'd2;
	localparam logic [9:0] CSR_TIMER_COMPARE = 10'd3;
	localparam logic [9:0] CSR_TIMER_COUNT   = 10'd4;
	localparam logic [9:0] CSR_SYSTEM_ID     = 10'd5;

	// ------------------------------------------------------------------
	// Misc
	// ------------------------------------------------------------------
	localparam int GPIO_IN_W  = 3;
	localparam int GPIO_OUT_W = 2;
	// "S3AE"
	localparam logic [31:0] SYSTEM_ID = 32'h5333_4145;
	// Short stretch so that simulation stays quick
	localparam int LED_STRETCH = 64;
	localparam int LED_CNT_W   = $clog2(LED_STRETCH + 1);

endpackage

// ==== rtl/bus_arbiter.sv ====
// ----------------------------------------------------------------------
// Two-master round-robin arbiter with region decoder
// The grant is registered one cycle after a request and held until the
// granted master drops cyc; unmapped regions get a zero-data ack from
// a built-in default responder so no access can hang
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module bus_arbiter (
	input  logic             sys_clk,
	input  logic             rst1,
	input  soc_pkg::wb_req_t m0_req_i,
	input  soc_pkg::wb_req_t m1_req_i,
	output soc_pkg::wb_rsp_t m0_rsp_o,
	output soc_pkg::wb_rsp_t m1_rsp_o,
	output soc_pkg::wb_req_t ram_req_o,
	output soc_pkg::wb_req_t csr_req_o,
	input  soc_pkg::wb_rsp_t ram_rsp_i,
	input  soc_pkg::wb_rsp_t csr_rsp_i
);
	import soc_pkg::*;

	// Grant state
	logic gnt_valid;
	logic gnt_sel;
	logic last_win;

	// Request lines
	logic m0_rq;
	logic m1_rq;
	logic pick_m1;

	// Granted path
	wb_req_t gnt_req;
	wb_rsp_t tgt_rsp;
	logic [2:0] region;
	logic active;
	logic hit_ram;
	logic hit_csr;
	logic hit_def;

	// Default responder
	logic def_ack;
	logic def_done;

	assign m0_rq = m0_req_i.cyc & m0_req_i.stb;
	assign m1_rq = m1_req_i.cyc & m1_req_i.stb;
	// On a tie the master not granted last wins
	assign pick_m1 = m1_rq & (~m0_rq | ~last_win);

	// ------------------------------------------------------------------
	// Grant register
	// ------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (rst1) begin
			gnt_valid <= 1'b0;
			gnt_sel   <= 1'b0;
			// Master 0 goes first after reset
			last_win  <= 1'b1;
		end else if (!gnt_valid) begin
			if (m0_rq | m1_rq) begin
				gnt_valid <= 1'b1;
				gnt_sel   <= pick_m1;
				last_win  <= pick_m1;
			end
		end else if (!gnt_req.cyc) begin
			// Owner released the bus
			gnt_valid <= 1'b0;
		end
	end

	// ------------------------------------------------------------------
	// Request mux and region decode
	// ------------------------------------------------------------------
	assign gnt_req = gnt_sel ? m1_req_i : m0_req_i;
	assign region  = gnt_req.adr[31:29];
	assign active  = gnt_valid & gnt_req.cyc & gnt_req.stb;
	assign hit_ram = (region == REGION_BRAM);
	assign hit_csr = (region == REGION_CSR);
	assign hit_def = ~hit_ram & ~hit_csr;

	// Both targets see the payload, stb only goes to the decoded one
	always_comb begin
		ram_req_o     = gnt_req;
		ram_req_o.cyc = gnt_valid & gnt_req.cyc;
		ram_req_o.stb = active & hit_ram;
		csr_req_o     = gnt_req;
		csr_req_o.cyc = gnt_valid & gnt_req.cyc;
		csr_req_o.stb = active & hit_csr;
	end

	// Default responder, one ack per strobe
	always_ff @(posedge sys_clk) begin
		if (rst1) begin
			def_ack  <= 1'b0;
			def_done <= 1'b0;
		end else begin
			def_ack  <= active & hit_def & ~def_ack & ~def_done;
			def_done <= active & hit_def & (def_done | def_ack);
		end
	end

	// ------------------------------------------------------------------
	// Response return
	// ------------------------------------------------------------------
	always_comb begin
		if (hit_ram) begin
			tgt_rsp = ram_rsp_i;
		end else if (hit_csr) begin
			tgt_rsp = csr_rsp_i;
		end else begin
			tgt_rsp.dat = 32'h0;
			tgt_rsp.ack = def_ack;
		end
	end

	// Only the owner sees the response
	always_comb begin
		m0_rsp_o = '0;
		m1_rsp_o = '0;
		if (gnt_valid) begin
			if (gnt_sel) begin
				m1_rsp_o = tgt_rsp;
			end else begin
				m0_rsp_o = tgt_rsp;
			end
		end
	end

endmodule

// ==== rtl/block_ram.sv ====
// ----------------------------------------------------------------------
// Word-wide block RAM target with byte-lane writes
// Acks one cycle after stb is seen, once per strobe
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module block_ram (
	input  logic             sys_clk,
	input  logic             rst1,
	input  soc_pkg::wb_req_t req_i,
	output soc_pkg::wb_rsp_t rsp_o
);
	import soc_pkg::*;

	logic [31:0] mem [0:(2**BRAM_ADDR_W)-1];
	logic [BRAM_ADDR_W-1:0] word_adr;
	logic [31:0] rd_q;
	logic ack_q;
	logic done_q;
	logic take;

	// Byte address to word index
	assign word_adr = req_i.adr[BRAM_ADDR_W+1:2];
	// New strobe not yet served
	assign take = req_i.stb & ~ack_q & ~done_q;

	// Storage and read port
	always_ff @(posedge sys_clk) begin
		if (take && req_i.we) begin
			for (int lane = 0; lane < 4; lane++) begin
				if (req_i.sel[lane]) begin
					mem[word_adr][lane*8 +: 8] <= req_i.dat[lane*8 +: 8];
				end
			end
		end
		rd_q <= mem[word_adr];
	end

	// Ack handshake
	// done_q blocks a second ack until stb drops
	always_ff @(posedge sys_clk) begin
		if (rst1) begin
			ack_q  <= 1'b0;
			done_q <= 1'b0;
		end else begin
			ack_q  <= take;
			done_q <= req_i.stb & (done_q | ack_q);
		end
	end

	assign rsp_o.dat = rd_q;
	assign rsp_o.ack = ack_q;

endmodule

// ==== rtl/csr_bridge.sv ====
// ----------------------------------------------------------------------
// Wishbone to CSR bus bridge
// Issues one CSR access per bus cycle, captures the read word and acks
// on the third edge after stb; then waits for stb to drop
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module csr_bridge (
	input  logic              sys_clk,
	input  logic              rst1,
	input  soc_pkg::wb_req_t  wb_req_i,
	output soc_pkg::wb_rsp_t  wb_rsp_o,
	output soc_pkg::csr_req_t csr_o,
	input  logic [31:0]       csr_dr_i
);
	import soc_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACCESS,
		ST_CAPTURE,
		ST_WAIT
	} state_t;

	state_t state;
	csr_req_t csr_q;
	logic [31:0] rd_q;
	logic ack_q;
	logic start;

	assign start = (state == ST_IDLE) & wb_req_i.cyc & wb_req_i.stb;

	// ------------------------------------------------------------------
	// Control FSM
	// ------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (rst1) begin
			state    <= ST_IDLE;
			csr_q.we <= 1'b0;
			ack_q    <= 1'b0;
		end else begin
			// Strobes default low
			csr_q.we <= 1'b0;
			ack_q    <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start) begin
						csr_q.we <= wb_req_i.we;
						state    <= ST_ACCESS;
					end
				end
				// Access on the CSR bus this cycle
				ST_ACCESS: state <= ST_CAPTURE;
				// Read word valid from the peripheral now
				ST_CAPTURE: begin
					ack_q <= 1'b1;
					state <= ST_WAIT;
				end
				ST_WAIT: begin
					if (!wb_req_i.stb) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Address and write data latched at start
	always_ff @(posedge sys_clk) begin
		if (start) begin
			csr_q.adr <= wb_req_i.adr[15:2];
			csr_q.dat <= wb_req_i.dat;
		end
	end

	// Read word
	always_ff @(posedge sys_clk) begin
		if (state == ST_CAPTURE) begin
			rd_q <= csr_dr_i;
		end
	end

	assign csr_o        = csr_q;
	assign wb_rsp_o.dat = rd_q;
	assign wb_rsp_o.ack = ack_q;

endmodule

// ==== rtl/sys_ctrl.sv ====
// ----------------------------------------------------------------------
// System controller on the CSR bus
// GPIO in and out, one timer with compare and auto-reload, the system
// ID word, and one-cycle GPIO and timer interrupt pulses
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module sys_ctrl (
	input  logic                           sys_clk,
	input  logic                           rst1,
	input  soc_pkg::csr_req_t              csr_i,
	output logic [31:0]                    csr_dr_o,
	input  logic [soc_pkg::GPIO_IN_W-1:0]  gpio_i,
	output logic [soc_pkg::GPIO_OUT_W-1:0] gpio_o,
	output soc_pkg::irq_t                  irq_o
);
	import soc_pkg::*;

	logic bank_sel;
	logic [9:0] ofs;
	logic wr;

	// GPIO
	logic [GPIO_IN_W-1:0] gpio_s1;
	logic [GPIO_IN_W-1:0] gpio_s2;
	logic [GPIO_IN_W-1:0] gpio_prev;
	logic [GPIO_OUT_W-1:0] gpio_out_q;

	// Timer
	logic tmr_en;
	logic tmr_ar;
	logic [31:0] tmr_cmp;
	logic [31:0] tmr_cnt;

	irq_t irq_q;

	assign bank_sel = (csr_i.adr[13:10] == SYSCTL_BANK);
	assign ofs      = csr_i.adr[9:0];
	assign wr       = bank_sel & csr_i.we;

	// Two-flop input synchronizer
	always_ff @(posedge sys_clk) begin
		gpio_s1 <= gpio_i;
		gpio_s2 <= gpio_s1;
	end

	// ------------------------------------------------------------------
	// Registers, timer and interrupts
	// ------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (rst1) begin
			// Track inputs during reset, no pulse on release
			gpio_prev  <= gpio_s2;
			gpio_out_q <= '0;
			tmr_en     <= 1'b0;
			tmr_ar     <= 1'b0;
			tmr_cmp    <= 32'h0;
			tmr_cnt    <= 32'h0;
			irq_q      <= '0;
		end else begin
			gpio_prev  <= gpio_s2;
			irq_q.gpio <= (gpio_s2 != gpio_prev);
			irq_q.timer <= 1'b0;

			// Counting
			if (tmr_en) begin
				if (tmr_cnt == tmr_cmp) begin
					irq_q.timer <= 1'b1;
					if (tmr_ar) begin
						tmr_cnt <= 32'h0;
					end else begin
						tmr_en <= 1'b0;
					end
				end else begin
					tmr_cnt <= tmr_cnt + 32'd1;
				end
			end

			// Bus writes take priority
			if (wr) begin
				case (ofs)
					CSR_GPIO_OUT: gpio_out_q <= csr_i.dat[GPIO_OUT_W-1:0];
					CSR_TIMER_CTRL: begin
						tmr_en <= csr_i.dat[0];
						tmr_ar <= csr_i.dat[1];
					end
					CSR_TIMER_COMPARE: tmr_cmp <= csr_i.dat;
					CSR_TIMER_COUNT: tmr_cnt <= csr_i.dat;
					default: ;
				endcase
			end
		end
	end

	// Registered read port, zero outside the bank
	always_ff @(posedge sys_clk) begin
		if (rst1) begin
			csr_dr_o <= 32'h0;
		end else begin
			csr_dr_o <= 32'h0;
			if (bank_sel) begin
				case (ofs)
					CSR_GPIO_IN: csr_dr_o <= {{(32-GPIO_IN_W){1'b0}}, gpio_s2};
					CSR_GPIO_OUT: csr_dr_o <= {{(32-GPIO_OUT_W){1'b0}}, gpio_out_q};
					CSR_TIMER_CTRL: csr_dr_o <= {30'h0, tmr_ar, tmr_en};
					CSR_TIMER_COMPARE: csr_dr_o <= tmr_cmp;
					CSR_TIMER_COUNT: csr_dr_o <= tmr_cnt;
					CSR_SYSTEM_ID: csr_dr_o <= SYSTEM_ID;
					default: csr_dr_o <= 32'h0;
				endcase
			end
		end
	end

	assign gpio_o = gpio_out_q;
	assign irq_o  = irq_q;

endmodule

// ==== rtl/bus_activity_leds.sv ====
// ----------------------------------------------------------------------
// Bus activity indicator
// Stretches each master's cyc into an LED pulse long enough to see
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module bus_activity_leds (
	input  logic       sys_clk,
	input  logic       rst1,
	input  logic       m0_cyc_i,
	input  logic       m1_cyc_i,
	output logic [1:0] led_o
);
	import soc_pkg::*;

	logic [1:0] cyc;
	logic [LED_CNT_W-1:0] cnt [2];

	assign cyc = {m1_cyc_i, m0_cyc_i};

	// One down-counter per master
	for (genvar i = 0; i < 2; i++) begin : g_led
		always_ff @(posedge sys_clk) begin
			if (rst1) begin
				cnt[i] <= '0;
			end else if (cyc[i]) begin
				// Reload while the cycle is active
				cnt[i] <= LED_CNT_W'(LED_STRETCH);
			end else if (cnt[i] != '0) begin
				cnt[i] <= cnt[i] - 1'b1;
			end
		end

		// Lit while counting down
		assign led_o[i] = (cnt[i] != '0);
	end

endmodule

// ==== rtl/soc_top.sv ====
// ----------------------------------------------------------------------
// Bus fabric top level
// Two masters share the bus through the arbiter; targets are the
// block RAM and the CSR bridge with the system controller behind it
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module soc_top (
	input  logic                           sys_clk,
	input  logic                           rst1,
	// Instruction master
	input  soc_pkg::wb_req_t               m0_req_i,
	output soc_pkg::wb_rsp_t               m0_rsp_o,
	// Data master
	input  soc_pkg::wb_req_t               m1_req_i,
	output soc_pkg::wb_rsp_t               m1_rsp_o,
	// Board I/O
	input  logic [soc_pkg::GPIO_IN_W-1:0]  gpio_i,
	output logic [soc_pkg::GPIO_OUT_W-1:0] gpio_o,
	output soc_pkg::irq_t                  irq_o,
	output logic [1:0]                     led_o
);
	import soc_pkg::*;

	// Target side of the arbiter
	wb_req_t ram_req;
	wb_rsp_t ram_rsp;
	wb_req_t brg_req;
	wb_rsp_t brg_rsp;

	// CSR bus
	csr_req_t csr_bus;
	logic [31:0] csr_dr;

	// ------------------------------------------------------------------
	// Arbiter and targets
	// ------------------------------------------------------------------
	bus_arbiter i_bus_arbiter (
		.sys_clk  (sys_clk),
		.rst1     (rst1),
		.m0_req_i (m0_req_i),
		.m1_req_i (m1_req_i),
		.m0_rsp_o (m0_rsp_o),
		.m1_rsp_o (m1_rsp_o),
		.ram_req_o(ram_req),
		.csr_req_o(brg_req),
		.ram_rsp_i(ram_rsp),
		.csr_rsp_i(brg_rsp)
	);

	block_ram i_block_ram (
		.sys_clk(sys_clk),
		.rst1   (rst1),
		.req_i  (ram_req),
		.rsp_o  (ram_rsp)
	);

	csr_bridge i_csr_bridge (
		.sys_clk (sys_clk),
		.rst1    (rst1),
		.wb_req_i(brg_req),
		.wb_rsp_o(brg_rsp),
		.csr_o   (csr_bus),
		.csr_dr_i(csr_dr)
	);

	// Only peripheral on the CSR bus
	sys_ctrl i_sys_ctrl (
		.sys_clk (sys_clk),
		.rst1    (rst1),
		.csr_i   (csr_bus),
		.csr_dr_o(csr_dr),
		.gpio_i  (gpio_i),
		.gpio_o  (gpio_o),
		.irq_o   (irq_o)
	);

	bus_activity_leds i_bus_activity_leds (
		.sys_clk (sys_clk),
		.rst1    (rst1),
		.m0_cyc_i(m0_req_i.cyc),
		.m1_cyc_i(m1_req_i.cyc),
		.led_o   (led_o)
	);

endmodule

// ==== bench/tb_soc.sv ====
// ----------------------------------------------------------------------
// Directed testbench for the bus fabric top level
// Two master models share the bus to reach the block RAM, the default
// responder and the system controller; a reference RAM checks reads
// Top module tb_soc is compiled last from the file list
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_soc;
	import soc_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int NUM_RAM    = 24;
	localparam int NUM_RR     = 4;
	localparam int TMR_N      = 20;
	localparam int MARGIN     = 8;
	// Worst access is a CSR read queued behind the other master
	localparam int ACC_CYC    = 14;
	localparam int NUM_ACC    = 3 * NUM_RAM + 5 * NUM_RR + 30;
	localparam int TEST_CYC   = NUM_ACC * ACC_CYC + 5 * (TMR_N + MARGIN)
		+ 5 * (LED_STRETCH + MARGIN) + 200;

	logic sys_clk;
	logic rst1;
	wb_req_t m0_req;
	wb_req_t m1_req;
	wb_rsp_t m0_rsp;
	wb_rsp_t m1_rsp;
	logic [GPIO_IN_W-1:0] gpio_i;
	logic [GPIO_OUT_W-1:0] gpio_o;
	irq_t irq_o;
	logic [1:0] led_o;

	integer seed = 32'hc0ff_e150;
	int err_cnt = 0;
	int chk_cnt = 0;
	// Reference model of the block RAM
	logic [31:0] ref_mem [0:(2**BRAM_ADDR_W)-1];
	logic [BRAM_ADDR_W-1:0] used_q [$];
	// Masters in the order their acks arrived
	bit ack_order [$];
	// Round-robin state with master 0 first after reset
	bit last_grant = 1'b1;

	soc_top i_soc_top (
		.sys_clk (sys_clk),
		.rst1    (rst1),
		.m0_req_i(m0_req),
		.m0_rsp_o(m0_rsp),
		.m1_req_i(m1_req),
		.m1_rsp_o(m1_rsp),
		.gpio_i  (gpio_i),
		.gpio_o  (gpio_o),
		.irq_o   (irq_o),
		.led_o   (led_o)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
	end

	// Hang guard sized from the test lengths
	initial begin
		#(TEST_CYC * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, a bus access or wait hung", TEST_CYC);
		$display("TEST FAILED");
		$finish;
	end

	// ------------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------------
	task automatic log_error(input string msg);
		err_cnt++;
		$display("error @ %0t: %s", $time, msg);
	endtask

	task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
		chk_cnt++;
		if (got !== exp) begin
			log_error($sformatf("%s: got %h, expected %h", what, got, exp));
		end
	endtask

	task automatic check_irq(input irq_t got, input irq_t exp, input string what);
		chk_cnt++;
		if (got !== exp) begin
			log_error($sformatf("%s: got irq %b, expected %b", what, got, exp));
		end
	endtask

	task automatic check_leds(input logic [1:0] got, input logic [1:0] exp, input string what);
		chk_cnt++;
		if (got !== exp) begin
			log_error($sformatf("%s: got leds %b, expected %b", what, got, exp));
		end
	endtask

	// ------------------------------------------------------------------
	// Bus helpers
	// ------------------------------------------------------------------
	function automatic logic [31:0] ram_adr(input logic [BRAM_ADDR_W-1:0] widx);
		logic [28:0] ofs;
		ofs = '0;
		ofs[BRAM_ADDR_W+1:2] = widx;
		return {REGION_BRAM, ofs};
	endfunction

	// Bank 1 sits at byte offset 0x1000 of the CSR region
	function automatic logic [31:0] csr_adr(input logic [9:0] ofs);
		return {REGION_CSR, 13'h0, SYSCTL_BANK, ofs, 2'b00};
	endfunction

	function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
		input logic [31:0] new_w, input logic [3:0] sel);
		logic [31:0] res;
		res = old_w;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				res[b*8 +: 8] = new_w[b*8 +: 8];
			end
		end
		return res;
	endfunction

	// One cycle from either master with the request held until ack
	task automatic bus_access(input bit mst, input logic [31:0] adr, input logic we,
		input logic [31:0] wdat, input logic [3:0] sel, output logic [31:0] rdat);
		wb_req_t req;
		wb_rsp_t rsp;
		req.adr = adr;
		req.dat = wdat;
		req.sel = sel;
		req.we  = we;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		// Leading edge also gives one idle cycle between accesses
		@(posedge sys_clk);
		#1;
		if (mst) begin
			m1_req = req;
		end else begin
			m0_req = req;
		end
		@(negedge sys_clk);
		rsp = mst ? m1_rsp : m0_rsp;
		while (!rsp.ack) begin
			@(negedge sys_clk);
			rsp = mst ? m1_rsp : m0_rsp;
		end
		rdat = rsp.dat;
		ack_order.push_back(mst);
		last_grant = mst;
		@(posedge sys_clk);
		#1;
		if (mst) begin
			m1_req = '0;
		end else begin
			m0_req = '0;
		end
	endtask

	task automatic bus_write(input bit mst, input logic [31:0] adr, input logic [31:0] dat,
		input logic [3:0] sel);
		logic [31:0] unused;
		bus_access(mst, adr, 1'b1, dat, sel, unused);
	endtask

	task automatic bus_read(input bit mst, input logic [31:0] adr, output logic [31:0] dat);
		bus_access(mst, adr, 1'b0, 32'h0, 4'hf, dat);
	endtask

	task automatic ram_write(input bit mst, input logic [BRAM_ADDR_W-1:0] widx,
		input logic [31:0] dat, input logic [3:0] sel);
		bus_write(mst, ram_adr(widx), dat, sel);
		ref_mem[widx] = merge_lanes(ref_mem[widx], dat, sel);
	endtask

	// Poll one interrupt line at falling edges for up to limit cycles
	task automatic wait_irq(input bit timer, input int limit, output bit seen, output irq_t val);
		seen = 1'b0;
		val = '0;
		for (int c = 0; c < limit && !seen; c++) begin
			@(negedge sys_clk);
			if (timer ? irq_o.timer : irq_o.gpio) begin
				seen = 1'b1;
				val = irq_o;
			end
		end
	endtask

	// ------------------------------------------------------------------
	// Tests
	// ------------------------------------------------------------------
	task automatic test_ram();
		logic [BRAM_ADDR_W-1:0] widx;
		logic [31:0] rd;
		for (int i = 0; i < NUM_RAM; i++) begin
			widx = BRAM_ADDR_W'($random(seed));
			used_q.push_back(widx);
			ram_write(i[0], widx, $random(seed), 4'hf);
		end
		// Random lane masks over the same words from the other master
		for (int i = 0; i < NUM_RAM; i++) begin
			ram_write(~i[0], used_q[i], $random(seed), 4'($random(seed)));
		end
		for (int i = 0; i < NUM_RAM; i++) begin
			bus_read(i[0], ram_adr(used_q[i]), rd);
			check_word(rd, ref_mem[used_q[i]], "RAM read-back");
		end
	endtask

	// Both masters start in the same cycle
	task automatic tie_pair(input logic we, input logic [BRAM_ADDR_W-1:0] w0,
		input logic [BRAM_ADDR_W-1:0] w1);
		logic [31:0] d0;
		logic [31:0] d1;
		logic [31:0] r0;
		logic [31:0] r1;
		bit first;
		d0 = $random(seed);
		d1 = $random(seed);
		first = ~last_grant;
		ack_order.delete();
		fork
			bus_access(1'b0, ram_adr(w0), we, d0, 4'hf, r0);
			bus_access(1'b1, ram_adr(w1), we, d1, 4'hf, r1);
		join
		check_word({31'h0, ack_order[0]}, {31'h0, first}, "tie winner");
		if (we) begin
			ref_mem[w0] = d0;
			ref_mem[w1] = d1;
		end else begin
			check_word(r0, ref_mem[w0], "master 0 read in a tie");
			check_word(r1, ref_mem[w1], "master 1 read in a tie");
		end
		last_grant = ~first;
	endtask

	task automatic test_arb();
		logic [BRAM_ADDR_W-1:0] w0;
		logic [31:0] rd;
		for (int r = 0; r < NUM_RR; r++) begin
			w0 = BRAM_ADDR_W'($random(seed));
			// Lone master 0 access hands the next tie to master 1
			if (r % 2 == 1) begin
				bus_read(1'b0, ram_adr(w0), rd);
			end
			tie_pair(1'b1, w0, w0 ^ BRAM_ADDR_W'(1));
			tie_pair(1'b0, w0, w0 ^ BRAM_ADDR_W'(1));
		end
	endtask

	task automatic test_default();
		logic [31:0] rd;
		logic [31:0] adr;
		bus_read(1'b0, {3'b010, 29'h0_0040}, rd);
		check_word(rd, 32'h0, "read of region 010");
		bus_read(1'b1, {3'b101, 29'h0_1234}, rd);
		check_word(rd, 32'h0, "read of region 101");
		// Same low address bits as live RAM words
		adr = ram_adr(used_q[0]);
		adr[31:29] = 3'b010;
		bus_write(1'b1, adr, 32'hdead_beef, 4'hf);
		adr = ram_adr(used_q[1]);
		adr[31:29] = 3'b101;
		bus_write(1'b0, adr, 32'h1bad_cafe, 4'hf);
		for (int i = 0; i < 2; i++) begin
			bus_read(i[0], ram_adr(used_q[i]), rd);
			check_word(rd, ref_mem[used_q[i]], "RAM after unmapped write");
		end
	endtask

	task automatic test_gpio_id();
		logic [31:0] rd;
		bit seen;
		irq_t irq;
		bus_write(1'b1, csr_adr(CSR_GPIO_OUT), 32'h2, 4'hf);
		check_word(32'(gpio_o), 32'h2, "gpio_o pins");
		bus_read(1'b0, csr_adr(CSR_GPIO_OUT), rd);
		check_word(rd, 32'h2, "GPIO_OUT read-back");
		@(posedge sys_clk);
		#1;
		gpio_i = 3'b101;
		wait_irq(1'b0, MARGIN, seen, irq);
		if (!seen) begin
			log_error("no gpio interrupt after an input change");
		end else begin
			// gpio set and timer clear
			check_irq(irq, irq_t'(2'b10), "gpio interrupt");
			@(negedge sys_clk);
			check_irq(irq_o, irq_t'(2'b00), "gpio pulse length");
		end
		bus_read(1'b1, csr_adr(CSR_GPIO_IN), rd);
		check_word(rd, 32'h5, "GPIO_IN after sync");
		bus_read(1'b0, csr_adr(CSR_SYSTEM_ID), rd);
		check_word(rd, 32'h5333_4145, "system ID");
	endtask

	task automatic test_timer();
		logic [31:0] rd;
		bit seen;
		irq_t irq;
		bus_write(1'b0, csr_adr(CSR_TIMER_COMPARE), TMR_N, 4'hf);
		// Enable with auto-reload
		bus_write(1'b0, csr_adr(CSR_TIMER_CTRL), 32'h3, 4'hf);
		for (int p = 0; p < 2; p++) begin
			wait_irq(1'b1, TMR_N + MARGIN, seen, irq);
			if (!seen) begin
				log_error($sformatf("auto-reload timer interrupt %0d did not arrive", p));
			end
		end
		bus_read(1'b1, csr_adr(CSR_TIMER_COUNT), rd);
		chk_cnt++;
		if (rd >= TMR_N) begin
			log_error($sformatf("timer count %0d is not below compare %0d", rd, TMR_N));
		end
		// One-shot run from zero
		bus_write(1'b1, csr_adr(CSR_TIMER_CTRL), 32'h0, 4'hf);
		bus_write(1'b1, csr_adr(CSR_TIMER_COUNT), 32'h0, 4'hf);
		bus_write(1'b1, csr_adr(CSR_TIMER_CTRL), 32'h1, 4'hf);
		wait_irq(1'b1, TMR_N + MARGIN, seen, irq);
		if (!seen) begin
			log_error("one-shot timer interrupt did not arrive");
		end else begin
			check_irq(irq, irq_t'(2'b01), "one-shot timer interrupt");
		end
		bus_read(1'b0, csr_adr(CSR_TIMER_CTRL), rd);
		check_word(rd, 32'h0, "timer control after one-shot");
		wait_irq(1'b1, TMR_N + MARGIN, seen, irq);
		chk_cnt++;
		if (seen) begin
			log_error("one-shot timer fired a second time");
		end
	endtask

	task automatic test_leds();
		logic [31:0] rd;
		logic [1:0] lit;
		repeat (LED_STRETCH + MARGIN) @(negedge sys_clk);
		check_leds(led_o, 2'b00, "LEDs after idle");
		for (int m = 0; m < 2; m++) begin
			lit = m[0] ? 2'b10 : 2'b01;
			fork
				bus_read(m[0], csr_adr(CSR_SYSTEM_ID), rd);
				begin
					repeat (3) @(negedge sys_clk);
					check_leds(led_o, lit, "LED during a cycle");
				end
			join
			repeat (LED_STRETCH / 2) @(negedge sys_clk);
			check_leds(led_o, lit, "LED held after a cycle");
			repeat (LED_STRETCH / 2 + MARGIN) @(negedge sys_clk);
			check_leds(led_o, 2'b00, "LED after the stretch");
		end
	endtask

	// ------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------
	initial begin
		m0_req = '0;
		m1_req = '0;
		gpio_i = '0;
		rst1 = 1'b1;
		repeat (3) @(posedge sys_clk);
		#1;
		rst1 = 1'b0;
		@(negedge sys_clk);
		check_irq(irq_o, irq_t'(2'b00), "interrupts after reset");
		check_leds(led_o, 2'b00, "LEDs after reset");
		check_word(32'(gpio_o), 32'h0, "gpio_o after reset");
		test_ram();
		test_arb();
		test_default();
		test_gpio_id();
		test_timer();
		test_leds();
		$display("Run complete: %0d checks, %0d errors", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
rtl/soc_pkg.sv
rtl/bus_arbiter.sv
rtl/block_ram.sv
rtl/csr_bridge.sv
rtl/sys_ctrl.sv
rtl/bus_activity_leds.sv
rtl/soc_top.sv
bench/tb_soc.sv
